//--- bench/lane_model.svh
/*
 * Lane reference model
 * Register and mask state, expected commit computation and queue
 */

lane_pkg::data_t                   model_regs [lane_pkg::NUM_REGS];
logic [lane_pkg::MASK_ENTRIES-1:0] model_mask;
lane_pkg::commit_t                 expected_q [$];

// Registers and mask start at zero, nothing outstanding
function automatic void model_clear();
	for (int i = 0; i < lane_pkg::NUM_REGS; i++) begin
		model_regs[i] = '0;
	end
	model_mask = '0;
	expected_q.delete();
endfunction

// Commands apply in order, so the state seen here is the state decode sees
function automatic void model_push(input lane_pkg::command_t c);
	lane_pkg::data_t   a;
	lane_pkg::data_t   b;
	lane_pkg::data_t   d;
	lane_pkg::data_t   r;
	lane_pkg::commit_t want;
	logic              en;
	a = model_regs[c.src1];
	b = c.use_scalar ? c.scalar : model_regs[c.src2];
	d = model_regs[c.src3];
	case (c.op)
		lane_pkg::op_add:    r = a + b;
		lane_pkg::op_sub:    r = a - b;
		lane_pkg::op_mul:    r = a * b;
		lane_pkg::op_mad:    r = a * b + d;
		lane_pkg::op_and:    r = a & b;
		lane_pkg::op_or:     r = a | b;
		lane_pkg::op_xor:    r = a ^ b;
		lane_pkg::op_shl:    r = a << b[4:0];
		lane_pkg::op_cmp_lt: r = (a < b) ? 32'd1 : 32'd0;
		lane_pkg::op_cmp_eq: r = (a == b) ? 32'd1 : 32'd0;
		default:             r = '0;
	endcase
	en = !c.masked || model_mask[c.mask_sel];
	want.valid    = 1'b1;
	want.dst_kind = c.dst_kind;
	want.dst      = c.dst;
	want.data     = r;
	want.written  = en;
	// Mask entries take bit 0 of the result
	if (en && c.dst_kind == lane_pkg::dst_reg) begin
		model_regs[c.dst] = r;
	end else if (en) begin
		model_mask[lane_pkg::mask_idx_t'(c.dst)] = r[0];
	end
	expected_q.push_back(want);
endfunction

//--- bench/tb_lane_unit.sv
/*
 * Lane testbench
 * Clock, reset, credit-holding driver, random commands
 * Commit checker against the reference model, report
 */
`timescale 1ns/10ps

module tb_lane_unit;

	localparam int QUEUE_DEPTH = lane_pkg::QUEUE_DEPTH;
	localparam int TIMEOUT     = 2000;

	logic               clock;
	logic               reset;
	logic               cmd_valid;
	lane_pkg::command_t cmd;
	logic               credit_return;
	lane_pkg::commit_t  commit;

	int          credits;
	int          min_credits;
	int          sent;
	int          returned;
	int          errors;
	int          test_errors;
	int          tests_run;
	logic        timed_out;
	logic [31:0] lcg_state;

	`include "lane_model.svh"

	lane_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
		.credit_return(credit_return), .commit(commit)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("mismatch %s got %h expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
		test_errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Cycle step with output sampling at the falling edge

	task automatic next_cycle();
		lane_pkg::commit_t want;
		@(negedge clock);
		if (credit_return) begin
			returned++;
			credits++;
			if (credits > QUEUE_DEPTH) begin
				$display("credit returned with no command outstanding");
				test_errors++;
			end
		end
		if (commit.valid && expected_q.size() == 0) begin
			$display("commit appeared with no command outstanding");
			test_errors++;
		end else if (commit.valid) begin
			want = expected_q.pop_front();
			compare("commit.dst_kind", 32'(commit.dst_kind), 32'(want.dst_kind));
			compare("commit.dst", 32'(commit.dst), 32'(want.dst));
			compare("commit.data", commit.data, want.data);
			compare("commit.written", 32'(commit.written), 32'(want.written));
		end
	endtask

	// Waits for a credit, then drives one command for one cycle
	task automatic send(input lane_pkg::command_t c);
		int waited;
		waited = 0;
		while (credits == 0 && !timed_out && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (!timed_out && credits == 0) begin
			timeout_fail("no credit came back for the next command");
		end else if (!timed_out) begin
			cmd_valid = 1'b1;
			cmd       = c;
			model_push(c);
			credits--;
			sent++;
			if (credits < min_credits) begin
				min_credits = credits;
			end
			next_cycle();
			cmd_valid = 1'b0;
		end
	endtask

	// Every credit comes back before its command commits
	task automatic drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && !timed_out && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (!timed_out && expected_q.size() != 0) begin
			timeout_fail("lane did not commit all outstanding commands");
		end
	endtask

	task automatic end_test(input string name);
		drain();
		compare("credit_return count", returned, sent);
		$display("test %s %s, %0d errors", name,
			(test_errors == 0) ? "passed" : "failed", test_errors);
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	function automatic lane_pkg::command_t random_cmd();
		lane_pkg::command_t c;
		logic [31:0]        r;
		r = lcg_next();
		c = '0;
		c.dst        = r[31:28];
		c.src1       = r[27:24];
		c.src2       = r[23:20];
		c.src3       = r[19:16];
		c.use_scalar = r[15];
		c.op         = lane_pkg::op_t'(4'((lcg_next() >> 20) % 32'd10));
		c.scalar     = lcg_next();
		return c;
	endfunction

	// Or of a register with itself rewrites it and shows its value
	task automatic read_back();
		lane_pkg::command_t c;
		for (int i = 0; i < lane_pkg::NUM_REGS; i++) begin
			c = '0;
			c.op   = lane_pkg::op_or;
			c.dst  = 4'(i);
			c.src1 = 4'(i);
			c.src2 = 4'(i);
			send(c);
		end
	endtask

	task automatic check_reset_state();
		for (int k = 0; k < 20; k++) begin
			next_cycle();
		end
		compare("credit_return count", returned, 0);
		read_back();
		end_test("reset state");
	endtask

	task automatic run_arithmetic();
		lane_pkg::command_t c;
		// Load every register with a random word first
		for (int i = 0; i < lane_pkg::NUM_REGS; i++) begin
			c = '0;
			c.op         = lane_pkg::op_or;
			c.dst        = 4'(i);
			c.src1       = 4'(i);
			c.use_scalar = 1'b1;
			c.scalar     = lcg_next();
			send(c);
		end
		for (int k = 0; k < 200; k++) begin
			send(random_cmd());
		end
		end_test("arithmetic");
	endtask

	task automatic run_hazards();
		lane_pkg::command_t c;
		lane_pkg::reg_idx_t prev;
		prev = 4'd0;
		for (int k = 0; k < 40; k++) begin
			c = random_cmd();
			c.src1 = prev;
			c.src3 = prev;
			// Every other command reads the previous result on two ports
			if (k % 2 == 0) begin
				c.src2       = prev;
				c.use_scalar = 1'b0;
			end
			prev = c.dst;
			send(c);
		end
		end_test("hazards");
	endtask

	task automatic run_masking();
		lane_pkg::command_t c;
		int                 masked_off;
		masked_off = 0;
		// Even entries set by an equal compare, odd ones cleared
		for (int e = 0; e < lane_pkg::MASK_ENTRIES; e++) begin
			c = '0;
			if (e % 2 == 0) begin
				c.op = lane_pkg::op_cmp_eq;
			end else begin
				c.op = lane_pkg::op_cmp_lt;
			end
			c.dst_kind = lane_pkg::dst_mask;
			c.dst      = 4'(e);
			c.src1     = 4'd1;
			c.src2     = 4'd1;
			send(c);
		end
		for (int k = 0; k < 40; k++) begin
			c = random_cmd();
			c.masked   = 1'b1;
			c.mask_sel = lane_pkg::mask_idx_t'(lcg_next() >> 29);
			if (!model_mask[c.mask_sel]) begin
				masked_off++;
			end
			send(c);
		end
		read_back();
		if (masked_off == 0) begin
			$display("no command was masked off in the masking test");
			test_errors++;
		end
		end_test("masking");
	endtask

	// Dependent chain stalls decode, so the queue fills and credits run out
	task automatic run_credit_flow();
		lane_pkg::command_t c;
		lane_pkg::reg_idx_t prev;
		prev        = 4'd1;
		min_credits = QUEUE_DEPTH;
		for (int k = 0; k < 60; k++) begin
			c = random_cmd();
			c.op   = lane_pkg::op_mad;
			c.src1 = prev;
			c.src3 = prev;
			prev   = c.dst;
			send(c);
		end
		if (min_credits != 0) begin
			$display("queue never filled during the credit test");
			test_errors++;
		end
		end_test("credit flow");
	endtask

	initial begin
		clock       = 1'b0;
		reset       = 1'b1;
		cmd_valid   = 1'b0;
		cmd         = '0;
		credits     = QUEUE_DEPTH;
		min_credits = QUEUE_DEPTH;
		sent        = 0;
		returned    = 0;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		timed_out   = 1'b0;
		lcg_state   = 32'd83698;
		model_clear();
		repeat (16) @(negedge clock);
		reset = 1'b0;
		check_reset_state();
		run_arithmetic();
		run_hazards();
		run_masking();
		run_credit_flow();
		$display("%0d tests, %0d commands, %0d errors", tests_run, sent, errors);
		if (errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- hdl/lane_decode.sv
/*
 * Decode stage
 * Command queue with credit return, register and mask scoreboards
 * Operand read and the decode pipeline register
 */
`timescale 1ns/10ps

module lane_decode #(
	parameter int NUM_REGS     = lane_pkg::NUM_REGS,
	parameter int MASK_ENTRIES = lane_pkg::MASK_ENTRIES,
	parameter int QUEUE_DEPTH  = lane_pkg::QUEUE_DEPTH
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                cmd_valid,
	input  lane_pkg::command_t  cmd,
	output logic                credit_return,
	output lane_pkg::reg_idx_t  rd_idx1,
	output lane_pkg::reg_idx_t  rd_idx2,
	output lane_pkg::reg_idx_t  rd_idx3,
	input  lane_pkg::data_t     rd_data1,
	input  lane_pkg::data_t     rd_data2,
	input  lane_pkg::data_t     rd_data3,
	output lane_pkg::mask_idx_t mask_sel,
	input  logic                mask_bit,
	input  logic                wb_reg_release,
	input  logic                wb_mask_release,
	input  lane_pkg::reg_idx_t  wb_dst,
	output lane_pkg::decoded_t  decoded
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	lane_pkg::command_t      queue [QUEUE_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	lane_pkg::command_t      head;
	logic                    hazard;
	logic                    pop;
	logic [NUM_REGS-1:0]     reg_pending;
	logic [MASK_ENTRIES-1:0] mask_pending;
	logic                    issue_valid;
	lane_pkg::command_t      issue_cmd;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Command queue

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			queue[wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
		end
	end

	assign head = queue[rd_ptr];

	////////////////////////////////////////////////////////////
	// Scoreboard

	// Sources the head actually reads
	always_comb begin
		hazard = reg_pending[head.src1];
		if (!head.use_scalar) begin
			hazard = hazard | reg_pending[head.src2];
		end
		if (head.op == lane_pkg::op_mad) begin
			hazard = hazard | reg_pending[head.src3];
		end
		if (head.masked) begin
			hazard = hazard | mask_pending[head.mask_sel];
		end
		// A second writer waits until the first one retires
		if (head.dst_kind == lane_pkg::dst_reg) begin
			hazard = hazard | reg_pending[head.dst];
		end else begin
			hazard = hazard | mask_pending[lane_pkg::mask_idx_t'(head.dst)];
		end
	end

	assign pop = (count != '0) && !hazard;

	always_ff @(posedge clock) begin
		if (reset) begin
			reg_pending  <= '0;
			mask_pending <= '0;
		end else begin
			if (wb_reg_release) begin
				reg_pending[wb_dst] <= 1'b0;
			end
			if (wb_mask_release) begin
				mask_pending[lane_pkg::mask_idx_t'(wb_dst)] <= 1'b0;
			end
			if (pop && head.dst_kind == lane_pkg::dst_reg) begin
				reg_pending[head.dst] <= 1'b1;
			end
			if (pop && head.dst_kind == lane_pkg::dst_mask) begin
				mask_pending[lane_pkg::mask_idx_t'(head.dst)] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Issue, operand read, decode register

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid   <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			issue_valid   <= pop;
			credit_return <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			issue_cmd <= head;
		end
	end

	assign rd_idx1  = issue_cmd.src1;
	assign rd_idx2  = issue_cmd.src2;
	assign rd_idx3  = issue_cmd.src3;
	assign mask_sel = issue_cmd.mask_sel;

	always_ff @(posedge clock) begin
		if (reset) begin
			decoded.valid <= 1'b0;
		end else begin
			decoded.valid    <= issue_valid;
			decoded.op       <= issue_cmd.op;
			decoded.dst_kind <= issue_cmd.dst_kind;
			decoded.dst      <= issue_cmd.dst;
			decoded.src1     <= rd_data1;
			decoded.src2     <= issue_cmd.use_scalar ? issue_cmd.scalar : rd_data2;
			decoded.src3     <= rd_data3;
			decoded.enable   <= !issue_cmd.masked || mask_bit;
		end
	end

	// Sender must hold a credit for every push
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		cmd_valid |-> (count < CNT_W'(QUEUE_DEPTH)))
		else $error("command pushed into a full queue");

	a_reg_release: assert property (@(posedge clock) disable iff (reset)
		wb_reg_release |-> reg_pending[wb_dst])
		else $error("release of a register that is not pending");

	a_mask_release: assert property (@(posedge clock) disable iff (reset)
		wb_mask_release |-> mask_pending[lane_pkg::mask_idx_t'(wb_dst)])
		else $error("release of a mask entry that is not pending");

endmodule

//--- hdl/lane_execute.sv
/*
 * Execute stage
 * Arithmetic unit and the execute pipeline register
 */
`timescale 1ns/10ps

module lane_execute (
	input  logic               clock,
	input  logic               reset,
	input  lane_pkg::decoded_t decoded,
	output lane_pkg::commit_t  result
);

	lane_pkg::data_t alu_out;

	// All results wrap at 32 bits, compares are unsigned
	always_comb begin
		case (decoded.op)
			lane_pkg::op_add: alu_out = decoded.src1 + decoded.src2;
			lane_pkg::op_sub: alu_out = decoded.src1 - decoded.src2;
			lane_pkg::op_mul: alu_out = decoded.src1 * decoded.src2;
			lane_pkg::op_mad: alu_out = decoded.src1 * decoded.src2 + decoded.src3;
			lane_pkg::op_and: alu_out = decoded.src1 & decoded.src2;
			lane_pkg::op_or:  alu_out = decoded.src1 | decoded.src2;
			lane_pkg::op_xor: alu_out = decoded.src1 ^ decoded.src2;
			// Shift amount from the low five bits only
			lane_pkg::op_shl: alu_out = decoded.src1 << decoded.src2[4:0];
			lane_pkg::op_cmp_lt: begin
				alu_out = (decoded.src1 < decoded.src2) ? 32'd1 : 32'd0;
			end
			lane_pkg::op_cmp_eq: begin
				alu_out = (decoded.src1 == decoded.src2) ? 32'd1 : 32'd0;
			end
			default: alu_out = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Execute register

	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid    <= decoded.valid;
			result.dst_kind <= decoded.dst_kind;
			result.dst      <= decoded.dst;
			result.data     <= alu_out;
			// Masked off commands still retire, with no write
			result.written  <= decoded.enable;
		end
	end

	// Opcode comes straight from the scalar unit's command
	a_known_op: assert property (@(posedge clock) disable iff (reset)
		decoded.valid |-> decoded.op inside {
			lane_pkg::op_add, lane_pkg::op_sub, lane_pkg::op_mul,
			lane_pkg::op_mad, lane_pkg::op_and, lane_pkg::op_or,
			lane_pkg::op_xor, lane_pkg::op_shl, lane_pkg::op_cmp_lt,
			lane_pkg::op_cmp_eq})
		else $error("unknown opcode in execute");

endmodule

//--- hdl/lane_mask_reg.sv
/*
 * Mask register
 * One condition bit per entry, written by result, read by decode
 */
`timescale 1ns/10ps

module lane_mask_reg #(
	parameter int MASK_ENTRIES = lane_pkg::MASK_ENTRIES
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                we,
	input  lane_pkg::mask_idx_t wr_sel,
	input  logic                wr_bit,
	input  lane_pkg::mask_idx_t rd_sel,
	output logic                rd_bit
);

	logic [MASK_ENTRIES-1:0] bits;

	always_ff @(posedge clock) begin
		if (reset) begin
			bits <= '0;
		end else if (we) begin
			bits[wr_sel] <= wr_bit;
		end
	end

	assign rd_bit = bits[rd_sel];

endmodule

//--- hdl/lane_pkg.sv
/*
 * Lane package
 * Word and index widths, opcodes, destination kinds
 * Command, decode and commit structs
 */
package lane_pkg;

	// Default sizes, overridden through the top level parameters
	parameter int NUM_REGS     = 16;
	parameter int MASK_ENTRIES = 8;
	parameter int QUEUE_DEPTH  = 4;

	typedef logic [31:0] data_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [2:0]  mask_idx_t;

	typedef enum logic [3:0] {
		op_add    = 4'd0,
		op_sub    = 4'd1,
		op_mul    = 4'd2,
		op_mad    = 4'd3,
		op_and    = 4'd4,
		op_or     = 4'd5,
		op_xor    = 4'd6,
		op_shl    = 4'd7,
		op_cmp_lt = 4'd8,
		op_cmp_eq = 4'd9
	} op_t;

	typedef enum logic {
		dst_reg  = 1'b0,
		dst_mask = 1'b1
	} dst_kind_t;

	// Command from the scalar unit
	typedef struct packed {
		op_t       op;
		dst_kind_t dst_kind;
		reg_idx_t  dst;         // low bits select a mask entry
		reg_idx_t  src1;
		reg_idx_t  src2;
		reg_idx_t  src3;
		logic      use_scalar;  // scalar replaces src2
		data_t     scalar;
		logic      masked;
		mask_idx_t mask_sel;
	} command_t;

	// Decode to execute
	typedef struct packed {
		logic      valid;
		op_t       op;
		dst_kind_t dst_kind;
		reg_idx_t  dst;
		data_t     src1;
		data_t     src2;
		data_t     src3;
		logic      enable;
	} decoded_t;

	// Execute to result, and the commit port
	typedef struct packed {
		logic      valid;
		dst_kind_t dst_kind;
		reg_idx_t  dst;
		data_t     data;
		logic      written;
	} commit_t;

endpackage

//--- hdl/lane_regfile.sv
/*
 * Lane register file
 * Three combinational read ports, one write port
 */
`timescale 1ns/10ps

module lane_regfile #(
	parameter int NUM_REGS = lane_pkg::NUM_REGS
) (
	input  logic               clock,
	input  logic               reset,
	input  lane_pkg::reg_idx_t rd_idx1,
	input  lane_pkg::reg_idx_t rd_idx2,
	input  lane_pkg::reg_idx_t rd_idx3,
	output lane_pkg::data_t    rd_data1,
	output lane_pkg::data_t    rd_data2,
	output lane_pkg::data_t    rd_data3,
	input  logic               we,
	input  lane_pkg::reg_idx_t wr_idx,
	input  lane_pkg::data_t    wr_data
);

	lane_pkg::data_t regs [NUM_REGS];

	// Every word starts at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Reads see the old value during a write cycle
	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];
	assign rd_data3 = regs[rd_idx3];

endmodule

//--- hdl/lane_result.sv
/*
 * Result stage
 * Write-back routing, scoreboard release, commit register
 */
`timescale 1ns/10ps

module lane_result (
	input  logic               clock,
	input  logic               reset,
	input  lane_pkg::commit_t  result,
	output logic               reg_we,
	output logic               mask_we,
	output lane_pkg::reg_idx_t wr_idx,
	output lane_pkg::data_t    wr_data,
	output logic               wb_reg_release,
	output logic               wb_mask_release,
	output lane_pkg::reg_idx_t wb_dst,
	output lane_pkg::commit_t  commit
);

	// Release on every retire, write only when the mask allows
	assign wb_reg_release  = result.valid && result.dst_kind == lane_pkg::dst_reg;
	assign wb_mask_release = result.valid && result.dst_kind == lane_pkg::dst_mask;
	assign wb_dst          = result.dst;

	assign reg_we  = wb_reg_release && result.written;
	assign mask_we = wb_mask_release && result.written;
	assign wr_idx  = result.dst;
	assign wr_data = result.data;

	// Commit keeps the computed data even when nothing was written
	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid    <= result.valid;
			commit.dst_kind <= result.dst_kind;
			commit.dst      <= result.dst;
			commit.data     <= result.data;
			commit.written  <= result.written;
		end
	end

endmodule

//--- hdl/lane_unit.sv
/*
 * SIMT vector lane, top level
 * Decode, execute and result stages around the register file and mask
 */
`timescale 1ns/10ps

module lane_unit #(
	parameter int NUM_REGS     = lane_pkg::NUM_REGS,
	parameter int MASK_ENTRIES = lane_pkg::MASK_ENTRIES,
	parameter int QUEUE_DEPTH  = lane_pkg::QUEUE_DEPTH
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               cmd_valid,
	input  lane_pkg::command_t cmd,
	output logic               credit_return,
	output lane_pkg::commit_t  commit
);

	lane_pkg::reg_idx_t  rd_idx1;
	lane_pkg::reg_idx_t  rd_idx2;
	lane_pkg::reg_idx_t  rd_idx3;
	lane_pkg::data_t     rd_data1;
	lane_pkg::data_t     rd_data2;
	lane_pkg::data_t     rd_data3;
	lane_pkg::mask_idx_t mask_sel;
	logic                mask_bit;
	logic                wb_reg_release;
	logic                wb_mask_release;
	lane_pkg::reg_idx_t  wb_dst;
	lane_pkg::decoded_t  decoded;
	lane_pkg::commit_t   result;
	logic                reg_we;
	logic                mask_we;
	lane_pkg::reg_idx_t  wr_idx;
	lane_pkg::data_t     wr_data;

	lane_decode #(
		.NUM_REGS(NUM_REGS),
		.MASK_ENTRIES(MASK_ENTRIES),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) decode0 (
		.clock(clock), .reset(reset),
		.cmd_valid(cmd_valid), .cmd(cmd), .credit_return(credit_return),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.mask_sel(mask_sel), .mask_bit(mask_bit),
		.wb_reg_release(wb_reg_release), .wb_mask_release(wb_mask_release),
		.wb_dst(wb_dst), .decoded(decoded)
	);

	lane_regfile #(.NUM_REGS(NUM_REGS)) regfile0 (
		.clock(clock), .reset(reset),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.we(reg_we), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	// Mask entry from the low destination bits, condition from data bit 0
	lane_mask_reg #(.MASK_ENTRIES(MASK_ENTRIES)) mask0 (
		.clock(clock), .reset(reset),
		.we(mask_we), .wr_sel(lane_pkg::mask_idx_t'(wr_idx)), .wr_bit(wr_data[0]),
		.rd_sel(mask_sel), .rd_bit(mask_bit)
	);

	lane_execute execute0 (
		.clock(clock), .reset(reset), .decoded(decoded), .result(result)
	);

	lane_result result0 (
		.clock(clock), .reset(reset), .result(result),
		.reg_we(reg_we), .mask_we(mask_we), .wr_idx(wr_idx), .wr_data(wr_data),
		.wb_reg_release(wb_reg_release), .wb_mask_release(wb_mask_release),
		.wb_dst(wb_dst), .commit(commit)
	);

endmodule

//--- list.f
+incdir+bench
hdl/lane_pkg.sv
hdl/lane_regfile.sv
hdl/lane_mask_reg.sv
hdl/lane_decode.sv
hdl/lane_execute.sv
hdl/lane_result.sv
hdl/lane_unit.sv
bench/tb_lane_unit.sv

//--- run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_lane_unit -o sim_lane \
	&& ./obj_dir/sim_lane > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
